//--- common/Fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Fetch ID width, gives the PC file depth.
`define FETCH_ID_BITS 5

// 16-bit parcels per 8-byte fetch block.
`define NUM_SLOTS 4

`define BTB_ENTRIES 16

// 64-byte lines.
`define IC_LINES 16

`define HIST_BITS 8

`endif

//--- common/FetchPkg.sv
`default_nettype none
`include "Fetch_macros.svh"

package FetchPkg;

    // Sequence number of one fetch block.
    typedef logic [`FETCH_ID_BITS-1:0] FetchID_t;

    // Global branch history.
    typedef logic [`HIST_BITS-1:0] BHist_t;

    typedef struct packed {
        logic predicted;
        logic taken;
    } BranchPredInfo;

    // --------------------
    // Per-fetch metadata, kept until the back end retires the fetch.
    // --------------------
    typedef struct packed {
        logic [30:0] pc;
        BHist_t hist;
        BranchPredInfo bpi;
        logic [1:0] branchPos;
    } PCFileEntry;

    // One parcel slot toward decode.
    typedef struct packed {
        logic valid;
        logic [30:0] pc;
        logic [15:0] instr;
        FetchID_t fetchID;
        logic predTaken;
    } IF_Instr;

endpackage

`default_nettype wire

//--- common/MemCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface MemCtrlIf;
    logic reqValid;
    // 64-byte line address.
    logic [25:0] reqAddr;
    logic [0:0] cacheID;
    logic [9:0] progress;
    logic busy;

    modport Cache (
        output reqValid,
        output reqAddr,
        output cacheID,
        input progress,
        input busy
    );

    modport Ctrl (
        input reqValid,
        input reqAddr,
        input cacheID,
        output progress,
        output busy
    );
endinterface

`default_nettype wire

//--- hdl/PCFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "Fetch_macros.svh"

module PCFile (
    input wire clk,
    input wire wen,
    input wire FetchPkg::FetchID_t waddr,
    input wire FetchPkg::PCFileEntry wdata,
    input wire FetchPkg::FetchID_t raddr0,
    input wire FetchPkg::FetchID_t raddr1,
    output FetchPkg::PCFileEntry rdata0,
    output FetchPkg::PCFileEntry rdata1
);
    import FetchPkg::*;

    localparam int Depth = 1 << `FETCH_ID_BITS;

    PCFileEntry entries[Depth];

    always_ff @(posedge clk) begin
        if (wen) begin
            entries[waddr] <= wdata;
        end
    end

    // Asynchronous reads.
    assign rdata0 = entries[raddr0];
    assign rdata1 = entries[raddr1];

endmodule

`default_nettype wire

//--- ifetch/BranchTargetBuffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "Fetch_macros.svh"

module BranchTargetBuffer (
    input wire clk,
    input wire rst,
    input wire [30:0] lookupPc,
    output logic branchFound,
    output logic branchTaken,
    output logic isJump,
    output logic [31:0] branchSrc,
    output logic [31:0] branchDst,
    output FetchPkg::BHist_t history,
    output FetchPkg::BranchPredInfo info,
    input wire predict,
    input wire updValid,
    input wire [31:0] updSrc,
    input wire [31:0] updDst,
    input wire updIsJump,
    input wire updTaken
);
    localparam int IdxBits = $clog2(`BTB_ENTRIES);
    localparam int TagBits = 29 - IdxBits;

    logic [`BTB_ENTRIES-1:0] entryValid;
    logic [`BTB_ENTRIES-1:0] entryJump;
    logic [TagBits-1:0] entryTag[`BTB_ENTRIES];
    logic [1:0] entrySlot[`BTB_ENTRIES];
    logic [30:0] entryTarget[`BTB_ENTRIES];
    logic [1:0] entryCtr[`BTB_ENTRIES];

    logic [IdxBits-1:0] lookupIdx;
    logic [TagBits-1:0] lookupTag;
    logic hit;

    logic [IdxBits-1:0] updIdx;
    logic [TagBits-1:0] updTag;
    logic [1:0] updSlot;
    logic updMatch;
    logic updAlloc;
    logic updTrain;

    // --------------------
    // Lookup
    // --------------------
    assign lookupIdx = lookupPc[IdxBits+1:2];
    assign lookupTag = lookupPc[30:IdxBits+2];

    // Branch must lie at or after the fetch entry point.
    assign hit = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag)
        && (entrySlot[lookupIdx] >= lookupPc[1:0]);

    always_comb begin
        branchFound = hit;
        branchTaken = hit && entryCtr[lookupIdx][1];
        isJump = hit && entryJump[lookupIdx];
        branchSrc = {lookupTag, lookupIdx, entrySlot[lookupIdx], 1'b0};
        branchDst = {entryTarget[lookupIdx], 1'b0};
        info.predicted = hit;
        info.taken = hit && (entryCtr[lookupIdx][1] || entryJump[lookupIdx]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (predict) begin
            history <= {history[`HIST_BITS-2:0], 1'b1};
        end
    end

    // --------------------
    // Update
    // --------------------
    assign updIdx = updSrc[IdxBits+2:3];
    assign updTag = updSrc[31:IdxBits+3];
    assign updSlot = updSrc[2:1];
    assign updMatch = entryValid[updIdx] && (entryTag[updIdx] == updTag)
        && (entrySlot[updIdx] == updSlot);
    assign updAlloc = updValid && updTaken && !updMatch;
    assign updTrain = updValid && updMatch;

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (updAlloc) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updAlloc) begin
            entryTag[updIdx] <= updTag;
            entrySlot[updIdx] <= updSlot;
            entryTarget[updIdx] <= updDst[31:1];
            entryJump[updIdx] <= updIsJump;
            entryCtr[updIdx] <= 2'd2;
        end else if (updTrain) begin
            if (updTaken) begin
                entryTarget[updIdx] <= updDst[31:1];
                entryJump[updIdx] <= updIsJump;
                if (entryCtr[updIdx] != 2'd3) begin
                    entryCtr[updIdx] <= entryCtr[updIdx] + 2'd1;
                end
            end else if (entryCtr[updIdx] != 2'd0) begin
                entryCtr[updIdx] <= entryCtr[updIdx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- ifetch/ICacheTable.sv
`timescale 1ns/1ps
`default_nettype none
`include "Fetch_macros.svh"

module ICacheTable (
    input wire clk,
    input wire rst,
    input wire lookupValid,
    input wire [30:0] lookupPc,
    output logic [28:0] lookupAddress,
    output logic stall,
    MemCtrlIf.Cache mc
);
    localparam int IdxBits = $clog2(`IC_LINES);
    localparam int TagBits = 26 - IdxBits;

    typedef enum logic [1:0] {
        Idle,
        Request,
        WaitBusy,
        WaitDone
    } FillState;

    FillState state;

    logic [`IC_LINES-1:0] lineValid;
    logic [TagBits-1:0] lineTag[`IC_LINES];

    logic [25:0] lookupLine;
    logic [IdxBits-1:0] lookupIdx;
    logic hit;
    logic miss;

    // Line under fill, frozen at the miss.
    logic [25:0] missLine;
    logic fillDone;

    // --------------------
    // Tag lookup
    // --------------------
    assign lookupLine = lookupPc[30:5];
    assign lookupIdx = lookupLine[IdxBits-1:0];
    assign hit = lineValid[lookupIdx] && (lineTag[lookupIdx] == lookupLine[25:IdxBits]);
    assign miss = lookupValid && !hit;

    assign lookupAddress = lookupPc[30:2];

    // Held from the miss cycle until the tag is installed.
    assign stall = (state != Idle) || miss;

    // --------------------
    // Fill sequencing
    // --------------------
    assign mc.reqValid = (state == Request);
    assign mc.reqAddr = missLine;
    assign mc.cacheID = 1'b0;

    // first low cycle after the controller went busy
    assign fillDone = (state == WaitDone) && !mc.busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (miss) begin
                        state <= Request;
                    end
                end
                Request: begin
                    state <= WaitBusy;
                end
                WaitBusy: begin
                    if (mc.busy) begin
                        state <= WaitDone;
                    end
                end
                WaitDone: begin
                    if (!mc.busy) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lineValid <= '0;
        end else if (fillDone) begin
            lineValid[missLine[IdxBits-1:0]] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == Idle) && miss) begin
            missLine <= lookupLine;
        end
        if (fillDone) begin
            lineTag[missLine[IdxBits-1:0]] <= missLine[25:IdxBits];
        end
    end

endmodule

`default_nettype wire

//--- ifetch/ProgramCounter.sv
`timescale 1ns/1ps
`default_nettype none
`include "Fetch_macros.svh"

module ProgramCounter (
    input wire clk,
    input wire rst,
    input wire en0,
    input wire en1,
    input wire redirect,
    input wire [31:0] redirPc,
    input wire FetchPkg::FetchID_t redirFetchID,
    input wire branchFound,
    input wire branchTaken,
    input wire isJump,
    input wire [31:0] branchSrc,
    input wire [31:0] branchDst,
    input wire FetchPkg::BHist_t history,
    input wire FetchPkg::BranchPredInfo info,
    output logic predict,
    input wire FetchPkg::FetchID_t pcReadAddr[1:0],
    output FetchPkg::PCFileEntry pcReadData[1:0],
    input wire FetchPkg::FetchID_t robCurFetchID,
    input wire [63:0] instr,
    output logic [31:0] pcRaw,
    output FetchPkg::FetchID_t fetchID,
    output FetchPkg::IF_Instr instrs[`NUM_SLOTS-1:0],
    output logic stall,
    input wire icacheStall
);
    import FetchPkg::*;

    localparam int NumSlots = `NUM_SLOTS;

    // Halfword PC of the block being looked up.
    logic [30:0] pc;

    // Stage 1 copy of the block fetched on en0.
    logic [30:0] pcLast;
    BHist_t histLast;
    BranchPredInfo infoLast;
    logic [1:0] branchPosLast;

    logic fire1;
    PCFileEntry pcfWrite;

    logic [NumSlots-1:0] slotValid;
    logic [NumSlots-1:0] slotPredTaken;
    logic [30:0] slotPc[NumSlots];
    logic [15:0] slotInstr[NumSlots];
    FetchID_t slotFetchID;

    assign pcRaw = {pc, 1'b0};

    // A redirect cancels the block in stage 1.
    assign fire1 = en1 && !redirect;

    assign predict = en0 && info.taken;
    assign stall = (robCurFetchID == fetchID) || icacheStall;

    // --------------------
    // Next PC and fetch ID
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchID <= '0;
        end else if (redirect) begin
            pc <= redirPc[31:1];
            fetchID <= redirFetchID + 1'b1;
        end else begin
            if (en1) begin
                fetchID <= fetchID + 1'b1;
            end
            if (en0) begin
                if (branchFound && (isJump || branchTaken)) begin
                    pc <= branchDst[31:1];
                end else begin
                    pc <= {pc[30:2] + 29'd1, 2'b00};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en0) begin
            pcLast <= pc;
            histLast <= history;
            infoLast <= info;
            branchPosLast <= branchSrc[2:1];
        end
    end

    // --------------------
    // Parcel slots
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
        end else if (fire1) begin
            for (int i = 0; i < NumSlots; i++) begin
                slotValid[i] <= (2'(i) >= pcLast[1:0])
                    && (!infoLast.taken || (2'(i) <= branchPosLast));
            end
        end else begin
            slotValid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire1) begin
            slotFetchID <= fetchID;
            for (int i = 0; i < NumSlots; i++) begin
                slotPc[i] <= {pcLast[30:2], 2'(i)};
                slotInstr[i] <= instr[16*i +: 16];
                slotPredTaken[i] <= infoLast.taken && (2'(i) == branchPosLast);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NumSlots; i++) begin
            instrs[i].valid = slotValid[i];
            instrs[i].pc = slotPc[i];
            instrs[i].instr = slotInstr[i];
            instrs[i].fetchID = slotFetchID;
            instrs[i].predTaken = slotPredTaken[i];
        end
    end

    // Metadata written under the fetch ID it is assigned.
    always_comb begin
        pcfWrite.pc = pcLast;
        pcfWrite.hist = histLast;
        pcfWrite.bpi = infoLast;
        pcfWrite.branchPos = branchPosLast;
    end

    PCFile pcFile (
        .clk(clk),
        .wen(fire1),
        .waddr(fetchID),
        .wdata(pcfWrite),
        .raddr0(pcReadAddr[0]),
        .raddr1(pcReadAddr[1]),
        .rdata0(pcReadData[0]),
        .rdata1(pcReadData[1])
    );

endmodule

`default_nettype wire

//--- hdl/FetchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "Fetch_macros.svh"

module FetchUnit (
    input wire clk,
    input wire rst,
    input wire fetchEn,
    input wire redirect,
    input wire [31:0] redirPc,
    input wire FetchPkg::FetchID_t redirFetchID,
    input wire updValid,
    input wire [31:0] updSrc,
    input wire [31:0] updDst,
    input wire updIsJump,
    input wire updTaken,
    input wire FetchPkg::FetchID_t pcReadAddr0,
    input wire FetchPkg::FetchID_t pcReadAddr1,
    output FetchPkg::PCFileEntry pcReadData0,
    output FetchPkg::PCFileEntry pcReadData1,
    input wire FetchPkg::FetchID_t robCurFetchID,
    input wire [63:0] instr,
    output logic [28:0] instrAddr,
    output FetchPkg::IF_Instr instrs[`NUM_SLOTS-1:0],
    output logic stall,
    output logic mcReqValid,
    output logic [25:0] mcReqAddr,
    output logic [0:0] mcCacheID,
    input wire [9:0] mcProgress,
    input wire mcBusy
);
    import FetchPkg::*;

    logic en0;
    logic en1;
    logic icacheStall;
    logic [31:0] pcRaw;

    logic branchFound;
    logic branchTaken;
    logic isJump;
    logic [31:0] branchSrc;
    logic [31:0] branchDst;
    BHist_t history;
    BranchPredInfo info;
    logic predict;

    FetchID_t readAddr[1:0];
    PCFileEntry readData[1:0];

    MemCtrlIf mcIf ();

    // --------------------
    // Stage enables
    // --------------------
    assign en0 = fetchEn && !stall;

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            en1 <= 1'b0;
        end else begin
            en1 <= en0;
        end
    end

    assign readAddr[0] = pcReadAddr0;
    assign readAddr[1] = pcReadAddr1;
    assign pcReadData0 = readData[0];
    assign pcReadData1 = readData[1];

    assign mcReqValid = mcIf.reqValid;
    assign mcReqAddr = mcIf.reqAddr;
    assign mcCacheID = mcIf.cacheID;
    assign mcIf.progress = mcProgress;
    assign mcIf.busy = mcBusy;

    ProgramCounter progCnt (
        .clk(clk),
        .rst(rst),
        .en0(en0),
        .en1(en1),
        .redirect(redirect),
        .redirPc(redirPc),
        .redirFetchID(redirFetchID),
        .branchFound(branchFound),
        .branchTaken(branchTaken),
        .isJump(isJump),
        .branchSrc(branchSrc),
        .branchDst(branchDst),
        .history(history),
        .info(info),
        .predict(predict),
        .pcReadAddr(readAddr),
        .pcReadData(readData),
        .robCurFetchID(robCurFetchID),
        .instr(instr),
        .pcRaw(pcRaw),
        .fetchID(),
        .instrs(instrs),
        .stall(stall),
        .icacheStall(icacheStall)
    );

    BranchTargetBuffer btb (
        .clk(clk),
        .rst(rst),
        .lookupPc(pcRaw[31:1]),
        .branchFound(branchFound),
        .branchTaken(branchTaken),
        .isJump(isJump),
        .branchSrc(branchSrc),
        .branchDst(branchDst),
        .history(history),
        .info(info),
        .predict(predict),
        .updValid(updValid),
        .updSrc(updSrc),
        .updDst(updDst),
        .updIsJump(updIsJump),
        .updTaken(updTaken)
    );

    // Looks up on fetchEn so the miss stall does not feed back into en0.
    ICacheTable icTable (
        .clk(clk),
        .rst(rst),
        .lookupValid(fetchEn),
        .lookupPc(pcRaw[31:1]),
        .lookupAddress(instrAddr),
        .stall(icacheStall),
        .mc(mcIf.Cache)
    );

endmodule

`default_nettype wire

//--- verif/FetchUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "Fetch_macros.svh"

module FetchUnit_tb;
    import FetchPkg::*;

    logic clk;
    logic rst;
    logic fetchEn;
    logic redirect;
    logic [31:0] redirPc;
    FetchID_t redirFetchID;
    logic updValid;
    logic [31:0] updSrc;
    logic [31:0] updDst;
    logic updIsJump;
    logic updTaken;
    FetchID_t pcReadAddr0;
    FetchID_t pcReadAddr1;
    PCFileEntry pcReadData0;
    PCFileEntry pcReadData1;
    FetchID_t robCurFetchID;
    logic [63:0] instr;
    logic [28:0] instrAddr;
    IF_Instr instrs[`NUM_SLOTS-1:0];
    logic stall;
    logic mcReqValid;
    logic [25:0] mcReqAddr;
    logic [0:0] mcCacheID;
    logic [9:0] mcProgress;
    logic mcBusy;

    // Model of the branch target buffer.
    logic btbValid[`BTB_ENTRIES];
    logic [24:0] btbTag[`BTB_ENTRIES];
    logic [1:0] btbSlot[`BTB_ENTRIES];
    logic [30:0] btbTarget[`BTB_ENTRIES];
    logic [1:0] btbCtr[`BTB_ENTRIES];
    logic btbJump[`BTB_ENTRIES];

    // Tag shadow of the instruction cache.
    logic shadowValid[`IC_LINES];
    logic [21:0] shadowTag[`IC_LINES];

    // What each fetch ID should hold in the PC file.
    logic recSet[32];
    logic [30:0] recPc[32];
    BHist_t recHist[32];
    BranchPredInfo recInfo[32];
    logic [1:0] recPos[32];

    logic [30:0] modelPc;
    FetchID_t modelID;
    BHist_t modelHist;
    int blocksSeen;
    int reqCount;
    int errorCount;
    int seenBefore;
    int busyCycles;
    integer seed = 26;
    logic [28:0] memAddr;

    FetchUnit FetchUnit_inst (
        .clk(clk), .rst(rst), .fetchEn(fetchEn), .redirect(redirect),
        .redirPc(redirPc), .redirFetchID(redirFetchID),
        .updValid(updValid), .updSrc(updSrc), .updDst(updDst),
        .updIsJump(updIsJump), .updTaken(updTaken),
        .pcReadAddr0(pcReadAddr0), .pcReadAddr1(pcReadAddr1),
        .pcReadData0(pcReadData0), .pcReadData1(pcReadData1),
        .robCurFetchID(robCurFetchID), .instr(instr), .instrAddr(instrAddr),
        .instrs(instrs), .stall(stall),
        .mcReqValid(mcReqValid), .mcReqAddr(mcReqAddr), .mcCacheID(mcCacheID),
        .mcProgress(mcProgress), .mcBusy(mcBusy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
            input logic [63:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
            abortRun();
        end
    endtask

    // Parcel contents hashed from the full halfword address.
    function automatic logic [15:0] parcelOf(input logic [28:0] blk, input int i);
        logic [31:0] h;
        h = {1'b0, blk, 2'(i)} * 32'h9E3779B1;
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic logic lineResident(input logic [25:0] line);
        return shadowValid[line[3:0]] && (shadowTag[line[3:0]] == line[25:4]);
    endfunction

    function automatic logic anySlotValid();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (instrs[i].valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        return seen;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic void predictBlock(input logic [30:0] pc, output logic [3:0] valid,
            output logic [3:0] predTaken, output logic [30:0] nextPc, output logic [1:0] pos,
            output BranchPredInfo bpi);
        logic [28:0] blk;
        logic [3:0] idx;
        blk = pc[30:2];
        idx = blk[3:0];
        bpi.predicted = btbValid[idx] && (btbTag[idx] == blk[28:4]) && (btbSlot[idx] >= pc[1:0]);
        bpi.taken = bpi.predicted && (btbCtr[idx] >= 2'd2 || btbJump[idx]);
        pos = btbSlot[idx];
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            valid[i] = (2'(i) >= pc[1:0]) && (!bpi.taken || 2'(i) <= pos);
            predTaken[i] = bpi.taken && (2'(i) == pos);
        end
        nextPc = bpi.taken ? btbTarget[idx] : {blk + 29'd1, 2'b00};
    endfunction

    task automatic checkBlock();
        logic [3:0] expValid;
        logic [3:0] expTaken;
        logic [30:0] nextPc;
        logic [1:0] pos;
        BranchPredInfo bpi;
        predictBlock(modelPc, expValid, expTaken, nextPc, pos, bpi);
        checkValue("line of fetched block resident", 64'(lineResident(modelPc[30:5])), 64'd1);
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            checkValue($sformatf("instrs[%0d].valid", i), 64'(instrs[i].valid), 64'(expValid[i]));
            if (expValid[i]) begin
                checkValue($sformatf("instrs[%0d].pc", i), 64'(instrs[i].pc),
                    64'({modelPc[30:2], 2'(i)}));
                checkValue($sformatf("instrs[%0d].instr", i), 64'(instrs[i].instr),
                    64'(parcelOf(modelPc[30:2], i)));
                checkValue($sformatf("instrs[%0d].fetchID", i), 64'(instrs[i].fetchID),
                    64'(modelID));
                checkValue($sformatf("instrs[%0d].predTaken", i), 64'(instrs[i].predTaken),
                    64'(expTaken[i]));
            end
        end
        recSet[modelID] = 1'b1;
        recPc[modelID] = modelPc;
        recHist[modelID] = modelHist;
        recInfo[modelID] = bpi;
        recPos[modelID] = pos;
        if (bpi.taken) begin
            modelHist = {modelHist[`HIST_BITS-2:0], 1'b1};
        end
        modelPc = nextPc;
        modelID = modelID + 5'd1;
        blocksSeen++;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && anySlotValid()) begin
                checkBlock();
            end
        end
    end

    // --------------------
    // Memory and controller
    // --------------------
    initial begin
        instr = '0;
        forever begin
            @(negedge clk);
            memAddr = instrAddr;
            @(posedge clk);
            #2 instr = {parcelOf(memAddr, 3), parcelOf(memAddr, 2),
                parcelOf(memAddr, 1), parcelOf(memAddr, 0)};
        end
    end

    initial begin
        mcBusy = 1'b0;
        mcProgress = '0;
        forever begin
            @(negedge clk);
            if (mcReqValid === 1'b1) begin
                checkValue("mcCacheID", 64'(mcCacheID), 64'd0);
                checkValue("mcReqAddr already filled", 64'(lineResident(mcReqAddr)), 64'd0);
                shadowValid[mcReqAddr[3:0]] = 1'b1;
                shadowTag[mcReqAddr[3:0]] = mcReqAddr[25:4];
                reqCount++;
                busyCycles = 3 + (($random(seed) & 32'h7fffffff) % 6);
                @(posedge clk);
                #2 mcBusy = 1'b1;
                repeat (busyCycles) @(posedge clk);
                #2 mcBusy = 1'b0;
            end
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic redirectFetch(input logic [31:0] pc, input FetchID_t id);
        redirect = 1'b1;
        redirPc = pc;
        redirFetchID = id;
        robCurFetchID = id;
        modelPc = pc[31:1];
        modelID = id + 5'd1;
        @(posedge clk);
        #2 redirect = 1'b0;
    endtask

    task automatic trainBranch(input logic [31:0] src, input logic [31:0] dst,
            input logic isJump, input logic taken);
        logic [3:0] idx;
        logic match;
        idx = src[6:3];
        match = btbValid[idx] && (btbTag[idx] == src[31:7]) && (btbSlot[idx] == src[2:1]);
        updValid = 1'b1;
        updSrc = src;
        updDst = dst;
        updIsJump = isJump;
        updTaken = taken;
        if (taken && !match) begin
            btbValid[idx] = 1'b1;
            btbTag[idx] = src[31:7];
            btbSlot[idx] = src[2:1];
            btbCtr[idx] = 2'd2;
        end else if (match && taken && btbCtr[idx] != 2'd3) begin
            btbCtr[idx] = btbCtr[idx] + 2'd1;
        end else if (match && !taken && btbCtr[idx] != 2'd0) begin
            btbCtr[idx] = btbCtr[idx] - 2'd1;
        end
        if (taken) begin
            btbTarget[idx] = dst[31:1];
            btbJump[idx] = isJump;
        end
        @(posedge clk);
        #2 updValid = 1'b0;
    endtask

    task automatic fetchBlocks(input int count);
        int target;
        int cycles;
        target = blocksSeen + count;
        cycles = 0;
        fetchEn = 1'b1;
        while (blocksSeen < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > 400) begin
                $display("Timeout: fetch did not deliver %0d blocks in time.", count);
                abortRun();
            end
        end
        #2 fetchEn = 1'b0;
    endtask

    task automatic drainFetch();
        int cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        // Fetch pipeline is two stages deep.
        repeat (3) @(posedge clk);
        while (!done) begin
            @(negedge clk);
            done = (stall === 1'b0);
            cycles++;
            if (!done && cycles > 100) begin
                $display("Timeout: stall stayed high after fetch was disabled.");
                abortRun();
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic compareEntry(input FetchID_t id, input PCFileEntry e);
        if (recSet[id]) begin
            checkValue($sformatf("pcReadData[%0d].pc", id), 64'(e.pc), 64'(recPc[id]));
            checkValue($sformatf("pcReadData[%0d].hist", id), 64'(e.hist), 64'(recHist[id]));
            checkValue($sformatf("pcReadData[%0d].bpi", id), 64'(e.bpi), 64'(recInfo[id]));
            if (recInfo[id].predicted) begin
                checkValue($sformatf("pcReadData[%0d].branchPos", id), 64'(e.branchPos),
                    64'(recPos[id]));
            end
        end
    endtask

    task automatic readBackPcFile();
        for (int id = 0; id < 32; id++) begin
            pcReadAddr0 = FetchID_t'(id);
            pcReadAddr1 = FetchID_t'(31 - id);
            @(negedge clk);
            compareEntry(FetchID_t'(id), pcReadData0);
            compareEntry(FetchID_t'(31 - id), pcReadData1);
            @(posedge clk);
            #2;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst = 1'b1;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirPc = '0;
        redirFetchID = '0;
        updValid = 1'b0;
        updSrc = '0;
        updDst = '0;
        updIsJump = 1'b0;
        updTaken = 1'b0;
        pcReadAddr0 = '0;
        pcReadAddr1 = '0;
        robCurFetchID = 5'd31;
        blocksSeen = 0;
        reqCount = 0;
        errorCount = 0;
        modelPc = '0;
        modelID = '0;
        modelHist = '0;
        for (int i = 0; i < 16; i++) begin
            btbValid[i] = 1'b0;
            shadowValid[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            recSet[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        @(posedge clk);
        #2;

        // Odd halfword entry, cold cache.
        redirectFetch(32'h0000_0102, 5'd5);
        fetchBlocks(12);
        drainFetch();
        checkValue("mcReqValid count", 64'(reqCount), 64'd2);

        // Same stream again, lines now resident.
        redirectFetch(32'h0000_0102, 5'd24);
        fetchBlocks(10);
        drainFetch();
        checkValue("mcReqValid count", 64'(reqCount), 64'd2);

        // Taken branch in slot 2 of block 0x200.
        trainBranch(32'h0000_0204, 32'h0000_02C2, 1'b0, 1'b1);
        redirectFetch(32'h0000_0200, 5'd12);
        fetchBlocks(6);
        drainFetch();
        checkValue("mcReqValid count", 64'(reqCount), 64'd4);

        // Counter trained down to strongly not taken.
        trainBranch(32'h0000_0204, 32'h0000_02C2, 1'b0, 1'b0);
        trainBranch(32'h0000_0204, 32'h0000_02C2, 1'b0, 1'b0);
        redirectFetch(32'h0000_0200, 5'd2);
        fetchBlocks(4);
        drainFetch();

        // ROB catches up with the next fetch ID.
        redirectFetch(32'h0000_0300, 5'd20);
        fetchBlocks(5);
        drainFetch();
        robCurFetchID = modelID;
        seenBefore = blocksSeen;
        fetchEn = 1'b1;
        repeat (12) @(posedge clk);
        @(negedge clk);
        checkValue("stall", 64'(stall), 64'd1);
        checkValue("blocks fetched while stalled", 64'(blocksSeen), 64'(seenBefore));
        @(posedge clk);
        #2 robCurFetchID = modelID + 5'd16;
        fetchBlocks(3);
        drainFetch();

        readBackPcFile();

        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abortRun();
        end
    end

endmodule

`default_nettype wire

//--- FetchUnit.f
+incdir+common
common/FetchPkg.sv
common/MemCtrlIf.sv
hdl/PCFile.sv
ifetch/BranchTargetBuffer.sv
ifetch/ICacheTable.sv
ifetch/ProgramCounter.sv
hdl/FetchUnit.sv
verif/FetchUnit_tb.sv

//--- Makefile
# Verilator flow for the fetch unit.

FILELIST := FetchUnit.f
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f $(FILELIST) --top-module FetchUnit

sim:
	verilator --binary --timing -f $(FILELIST) --top-module FetchUnit_tb -o FetchUnit_sim
	./obj_dir/FetchUnit_sim | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
